// ==== Makefile ====
# Verilator flow for the load/store unit testbench
SIM := obj_dir/lsu_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module lsu_tb -f project.f -o lsu_sim

run: compile
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/lsu_assertions.sv ====
// checks lsu_top against aligned-access rules only, addr_exp_i and mem_word_i come from the bench
`timescale 1ns/100ps

module lsu_assertions
  import lsu_pkg::*;
(
  input logic              clk,
  input logic              rst_n,
  input logic              req_ex_i,
  input logic              we_ex_i,
  input mem_size_e         size_ex_i,
  input ext_mode_e         sign_ext_ex_i,
  input logic [XLEN-1:0]   wdata_ex_i,
  input logic [OFFS_W-1:0] reg_offset_ex_i,
  input logic              ex_valid_i,
  input logic [XLEN-1:0]   rdata_ex_o,
  input logic              ready_ex_o,
  input logic              ready_wb_o,
  input logic              busy_o,
  input logic              data_req_o,
  input logic [XLEN-1:0]   data_addr_o,
  input logic              data_we_o,
  input logic [BE_W-1:0]   data_be_o,
  input logic [XLEN-1:0]   data_wdata_o,
  input logic              data_gnt_i,
  input logic              data_rvalid_i,
  input logic [XLEN-1:0]   addr_exp_i,     // address the core model asked for
  input logic [XLEN-1:0]   mem_word_i      // memory copy of the open transfer's word
);

  int fail_cnt = 0;   // read by the bench at the end

  // one-entry record of the accepted transfer
  mem_size_e         rec_size;
  ext_mode_e         rec_ext;
  logic [OFFS_W-1:0] rec_offs;
  logic              rec_we;
  logic              outst;      // granted, rvalid not yet seen
  logic              ex_hold;    // granted while ex stalled, ex not back yet
  logic              seen_req;
  logic              have_load;
  logic [XLEN-1:0]   last_load;  // expected held result

  ////////////////////
  // reference rules
  ////////////////////

  // lanes of an aligned access
  function automatic logic [BE_W-1:0] lanes_for(input mem_size_e size,
                                                input logic [OFFS_W-1:0] offs);
    logic [BE_W-1:0] lanes;
    case (size)
      SIZE_WORD: lanes = 4'b1111;
      SIZE_HALF: lanes = offs[1] ? 4'b1100 : 4'b0011;  // low or high half
      default:   lanes = 4'b0001 << offs;
    endcase
    return lanes;
  endfunction

  // each enabled lane k must carry source lane k - (addr offset - reg offset)
  function automatic logic store_lanes_ok(input logic [XLEN-1:0] wout,
                                          input logic [XLEN-1:0] src,
                                          input logic [BE_W-1:0] be,
                                          input logic [OFFS_W-1:0] aoffs,
                                          input logic [OFFS_W-1:0] roffs);
    logic [1:0] rot;
    logic [1:0] src_lane;
    logic       ok;
    int         k;
    rot = aoffs - roffs;
    ok  = 1'b1;
    for (k = 0; k < BE_W; k++)
    begin
      src_lane = 2'(k) - rot;  // wraps mod 4
      if (be[k] && (wout[8*k +: 8] != src[8*src_lane +: 8]))
        ok = 1'b0;
    end
    return ok;
  endfunction

  // shift the lane down, then fill above it
  function automatic logic [XLEN-1:0] extend_lane(input logic [XLEN-1:0] word,
                                                  input mem_size_e size,
                                                  input logic [OFFS_W-1:0] offs,
                                                  input ext_mode_e mode);
    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] keep;   // bits that came from memory
    logic            top;
    shifted = word >> {offs, 3'b000};
    keep    = (size == SIZE_HALF) ? 32'h0000_ffff : 32'h0000_00ff;
    top     = (size == SIZE_HALF) ? shifted[15] : shifted[7];
    if (mode == EXT_ZERO)
      top = 1'b0;
    else if (mode == EXT_ONES)
      top = 1'b1;
    if (size == SIZE_WORD)
      return word;           // no extension for words
    return (shifted & keep) | ({XLEN{top}} & ~keep);
  endfunction

  ////////////////////
  // tracking
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rec_size  <= SIZE_WORD;
      rec_ext   <= EXT_ZERO;
      rec_offs  <= '0;
      rec_we    <= 1'b0;
      outst     <= 1'b0;
      ex_hold   <= 1'b0;
      seen_req  <= 1'b0;
      have_load <= 1'b0;
      last_load <= '0;
    end
    else
    begin
      if (req_ex_i)
        seen_req <= 1'b1;
      if (data_rvalid_i)
        outst <= 1'b0;     // a new grant below wins
      if (data_rvalid_i && !rec_we)
      begin
        have_load <= 1'b1;
        last_load <= extend_lane(mem_word_i, rec_size, rec_offs, rec_ext);
      end
      if (data_req_o && data_gnt_i)
      begin
        outst    <= 1'b1;
        rec_size <= size_ex_i;
        rec_ext  <= sign_ext_ex_i;
        rec_offs <= addr_exp_i[OFFS_W-1:0];
        rec_we   <= we_ex_i;
        ex_hold  <= !ex_valid_i;
      end
      else if (ex_valid_i)
        ex_hold <= 1'b0;   // stall over
    end
  end

  ////////////////////
  // checks
  ////////////////////
  a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_req && !req_ex_i |-> !data_req_o && !busy_o && ready_ex_o && ready_wb_o)
    else begin fail_cnt++; $error("[ERROR] %0t: outputs not idle before first request", $time); end

  a_addr: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> data_addr_o == addr_exp_i)
    else begin fail_cnt++; $error("[ERROR] %0t: wrong data_addr_o", $time); end

  a_we: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> data_we_o == we_ex_i)
    else begin fail_cnt++; $error("[ERROR] %0t: wrong data_we_o", $time); end

  a_be: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> data_be_o == lanes_for(size_ex_i, addr_exp_i[OFFS_W-1:0]))
    else begin fail_cnt++; $error("[ERROR] %0t: wrong data_be_o", $time); end

  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && data_gnt_i && we_ex_i |->
      store_lanes_ok(data_wdata_o, wdata_ex_i,
                     lanes_for(size_ex_i, addr_exp_i[OFFS_W-1:0]),
                     addr_exp_i[OFFS_W-1:0], reg_offset_ex_i))
    else begin fail_cnt++; $error("[ERROR] %0t: store lanes misplaced", $time); end

  a_load: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i && !rec_we |->
      rdata_ex_o == extend_lane(mem_word_i, rec_size, rec_offs, rec_ext))
    else begin fail_cnt++; $error("[ERROR] %0t: wrong load result", $time); end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    have_load && !(data_rvalid_i && !rec_we) |-> rdata_ex_o == last_load)
    else begin fail_cnt++; $error("[ERROR] %0t: held load result changed", $time); end

  a_no_gnt_ready: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |-> !ready_ex_o)
    else begin fail_cnt++; $error("[ERROR] %0t: ready_ex_o high without grant", $time); end

  a_req_kept: assert property (@(posedge clk) disable iff (!rst_n)
    $past(data_req_o && !data_gnt_i) && req_ex_i |-> data_req_o)
    else begin fail_cnt++; $error("[ERROR] %0t: request dropped before grant", $time); end

  a_wb_wait: assert property (@(posedge clk) disable iff (!rst_n)
    outst && !data_rvalid_i && !ex_hold |-> !ready_wb_o)
    else begin fail_cnt++; $error("[ERROR] %0t: ready_wb_o high while waiting", $time); end

  a_one_open: assert property (@(posedge clk) disable iff (!rst_n)
    outst && !data_rvalid_i |-> !data_req_o)
    else begin fail_cnt++; $error("[ERROR] %0t: second request while one is open", $time); end

  a_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    ex_hold |-> !data_req_o)
    else begin fail_cnt++; $error("[ERROR] %0t: request raised during ex stall", $time); end

endmodule

// ==== bench/lsu_tb.sv ====
// random aligned traffic against a 64-word memory, only addresses 0 to 255 reach the memory
`timescale 1ns/100ps

module lsu_tb
  import lsu_pkg::*;
();

  localparam int CLK_NS   = 8;
  localparam int N_ACCESS = 200;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              req_ex_i;
  logic              we_ex_i;
  logic              addr_useincr_ex_i;
  logic              ex_valid_i;
  mem_size_e         size_ex_i;
  ext_mode_e         sign_ext_ex_i;
  logic [XLEN-1:0]   wdata_ex_i;
  logic [XLEN-1:0]   operand_a_ex_i;
  logic [XLEN-1:0]   operand_b_ex_i;
  logic [OFFS_W-1:0] reg_offset_ex_i;
  logic [XLEN-1:0]   rdata_ex_o;
  logic [XLEN-1:0]   data_addr_o;
  logic [XLEN-1:0]   data_wdata_o;
  logic [XLEN-1:0]   data_rdata_i;
  logic              ready_ex_o;
  logic              ready_wb_o;
  logic              busy_o;
  logic              data_req_o;
  logic              data_we_o;
  logic              data_gnt_i;
  logic              data_rvalid_i;
  logic [BE_W-1:0]   data_be_o;

  logic [XLEN-1:0]   mem [0:63];
  logic [XLEN-1:0]   exp_word;    // word of the open transfer, for the checker
  logic [XLEN-1:0]   req_addr;    // address the core means, for the checker
  logic              gnt_en;      // memory willing to grant this cycle
  int                seed = 27;
  int                retired = 0;
  int                issued = 0;
  int                timeouts = 0;

  lsu_top lsu_top_i (.*);

  bind lsu_top lsu_assertions chk_i (.*, .addr_exp_i(lsu_tb.req_addr),
                                     .mem_word_i(lsu_tb.exp_word));

  assign data_gnt_i = gnt_en && data_req_o;  // never grants without a request

  initial
  begin
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // one aligned access inside the 256-byte window
  task automatic drive_access();
    logic [31:0] r;
    logic [31:0] b;
    logic [31:0] addr;
    logic [1:0]  offs;
    r    = $random(seed);
    b    = $random(seed);
    offs = r[3:2];
    if (r[1:0] == 2'd0)
      offs = 2'b00;           // word
    else if (r[1:0] == 2'd1)
      offs[0] = 1'b0;         // half
    addr = {24'd0, r[9:4], offs};
    req_ex_i          <= 1'b1;
    we_ex_i           <= r[11];
    size_ex_i         <= mem_size_e'(r[1:0]);
    sign_ext_ex_i     <= ext_mode_e'(r[13:12]);
    reg_offset_ex_i   <= r[15:14];
    addr_useincr_ex_i <= r[10];
    operand_b_ex_i    <= b;
    operand_a_ex_i    <= r[10] ? (addr - b) : addr;  // sum wraps back to addr
    wdata_ex_i        <= $random(seed);
    req_addr          <= addr;
  endtask

  task automatic finish_run();
    int errs;
    errs = lsu_top_i.chk_i.fail_cnt;
    $display("accesses: %0d, check errors: %0d, timeouts: %0d", retired, errs, timeouts);
    if (errs == 0 && timeouts == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  endtask

  ////////////////////
  // memory model
  ////////////////////
  initial
  begin
    int         i;
    int         rv_wait;
    int         gnt_wait;
    logic       pend;
    logic       pend_we;
    logic [5:0] idx;
    for (i = 0; i < 64; i++)
      mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h81, i[7:0]};
    gnt_en        = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    exp_word      = '0;
    pend          = 1'b0;
    pend_we       = 1'b0;
    rv_wait       = 0;
    gnt_wait      = 0;
    forever
    begin
      @(posedge clk);
      if (!rst_n)
      begin
        pend = 1'b0;
        gnt_en        <= 1'b0;
        data_rvalid_i <= 1'b0;
      end
      else
      begin
        if (data_rvalid_i)
          pend = 1'b0;                       // response delivered
        else if (pend)
          rv_wait = rv_wait - 1;
        if (data_req_o && data_gnt_i)
        begin
          idx = data_addr_o[7:2];
          for (i = 0; i < 4; i++)
            if (data_we_o && data_be_o[i])
              mem[idx][8*i +: 8] = data_wdata_o[8*i +: 8];
          pend     = 1'b1;
          pend_we  = data_we_o;
          rv_wait  = 1 + rand_below(3);      // 1..3 cycles after grant
          exp_word <= mem[idx];
        end
        if (data_req_o && !data_gnt_i && gnt_wait != 0)
          gnt_wait = gnt_wait - 1;
        else
          gnt_wait = rand_below(3);          // 0..2 cycles of grant delay
        gnt_en        <= (gnt_wait == 0);
        data_rvalid_i <= pend && (rv_wait == 1);
        if (pend && rv_wait == 1 && !pend_we)
          data_rdata_i <= mem[idx];
        else
          data_rdata_i <= $random(seed);     // junk on store acks and idle
      end
    end
  end

  ////////////////////
  // core model
  ////////////////////
  initial
  begin
    req_ex_i          = 1'b0;
    we_ex_i           = 1'b0;
    size_ex_i         = SIZE_WORD;
    sign_ext_ex_i     = EXT_ZERO;
    wdata_ex_i        = '0;
    reg_offset_ex_i   = '0;
    operand_a_ex_i    = '0;
    operand_b_ex_i    = '0;
    addr_useincr_ex_i = 1'b0;
    ex_valid_i        = 1'b1;
    req_addr          = '0;
    rst_n             = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);             // quiet window after reset
    while (retired < N_ACCESS)
    begin
      @(posedge clk);
      if (req_ex_i && ready_ex_o && ex_valid_i)
        retired = retired + 1;
      if (!req_ex_i || (ready_ex_o && ex_valid_i))
      begin
        req_ex_i <= 1'b0;                  // slot free, maybe a gap
        if (issued < N_ACCESS && rand_below(4) != 0)
        begin
          drive_access();
          issued = issued + 1;
        end
      end
      ex_valid_i <= (rand_below(6) != 0);  // occasional ex stall
    end
    ex_valid_i <= 1'b1;
    @(posedge clk);
    while (busy_o)
      @(posedge clk);
    repeat (4) @(posedge clk);
    finish_run();
  end

  // watchdog
  initial
  begin
    #(N_ACCESS * 10 * CLK_NS + 20 * CLK_NS);
    timeouts = timeouts + 1;
    $display("watchdog expired before all accesses completed");
    finish_run();
  end

endmodule

// ==== logic/lsu_ctrl_fsm.sv ====
// tracks one granted transfer at a time, expects rvalid once per grant and in order
`timescale 1ns/100ps

module lsu_ctrl_fsm
  import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  // execute stage
  input  logic req_ex_i,      // access pending in ex
  input  logic ex_valid_i,    // ex stage moves on this cycle

  // memory handshake
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic data_req_o,

  // pipeline control
  output logic ready_ex_o,    // ex may retire its access
  output logic ready_wb_o,    // wb has what it needs
  output logic busy_o
);

  lsu_state_e state_q;
  lsu_state_e state_d;

  ////////////////////
  // state register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= LSU_IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////
  // next state and outputs
  ////////////////////
  always_comb
  begin
    state_d    = state_q;
    data_req_o = 1'b0;
    ready_ex_o = 1'b1;
    ready_wb_o = 1'b1;

    case (state_q)
      LSU_IDLE:
      begin
        data_req_o = req_ex_i;                 // forward straight through
        if (req_ex_i)
        begin
          ready_ex_o = data_gnt_i;             // core holds until accepted
          if (data_gnt_i)
          begin
            if (ex_valid_i)
              state_d = LSU_WAIT_RVALID;
            else
              state_d = LSU_WAIT_RVALID_EX_STALL; // ex stalled at grant
          end
        end
      end

      LSU_WAIT_RVALID:
      begin
        ready_wb_o = data_rvalid_i;            // wb waits on the response
        ready_ex_o = !req_ex_i;                // next access waits for a free slot
        if (data_rvalid_i)
        begin
          // slot frees up this cycle, so a new request may go out
          data_req_o = req_ex_i;
          if (req_ex_i && data_gnt_i)
          begin
            ready_ex_o = 1'b1;
            if (ex_valid_i)
              state_d = LSU_WAIT_RVALID;
            else
              state_d = LSU_WAIT_RVALID_EX_STALL;
          end
          else
          begin
            state_d = LSU_IDLE;                // ungranted req is retried from idle
          end
        end
      end

      LSU_WAIT_RVALID_EX_STALL:
      begin
        // req_ex_i still shows the access already granted, never reissue it
        if (data_rvalid_i)
        begin
          if (ex_valid_i)
            state_d = LSU_IDLE;
          else
            state_d = LSU_IDLE_EX_STALL;       // data held, ex still stuck
        end
        else if (ex_valid_i)
        begin
          state_d = LSU_WAIT_RVALID;           // stall gone, normal wait
        end
      end

      LSU_IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = LSU_IDLE;                  // stalled access finally retires
      end

      default:
      begin
        state_d = LSU_IDLE;
      end
    endcase
  end

  // anything in flight or being asked for
  assign busy_o = (state_q != LSU_IDLE) || data_req_o;

endmodule

// ==== logic/lsu_load_path.sv ====
// lane select assumes natural alignment, held load result reads zero until the first load
`timescale 1ns/100ps

module lsu_load_path
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // memory handshake
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic [XLEN-1:0]   data_rdata_i,

  // attributes of the access being issued
  input  logic              we_ex_i,
  input  mem_size_e         size_ex_i,
  input  ext_mode_e         sign_ext_ex_i,
  input  logic [OFFS_W-1:0] addr_offs_i,   // from store path address

  // to execute / write-back
  output logic [XLEN-1:0]   rdata_ex_o
);

  // attributes of the outstanding transfer
  mem_size_e         size_q;
  ext_mode_e         ext_q;
  logic [OFFS_W-1:0] offs_q;
  logic              we_q;       // outstanding transfer is a store

  logic [XLEN-1:0]   rdata_q;    // last load result
  logic [7:0]        byte_sel;
  logic [15:0]       half_sel;
  logic              msb;        // sign bit of the selected lane
  logic              fill;       // value for the upper bits
  logic [XLEN-1:0]   rdata_ext;

  ////////////////////
  // capture at grant
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q <= SIZE_WORD;
      ext_q  <= EXT_ZERO;
      offs_q <= '0;
      we_q   <= 1'b0;
    end
    else if (data_gnt_i)   // grant implies a request this cycle
    begin
      size_q <= size_ex_i;
      ext_q  <= sign_ext_ex_i;
      offs_q <= addr_offs_i;
      we_q   <= we_ex_i;
    end
  end

  ////////////////////
  // align and extend
  ////////////////////
  always_comb
  begin
    case (offs_q)
      2'd0:    byte_sel = data_rdata_i[7:0];
      2'd1:    byte_sel = data_rdata_i[15:8];
      2'd2:    byte_sel = data_rdata_i[23:16];
      default: byte_sel = data_rdata_i[31:24];
    endcase
  end

  // halves only at 0 or 2
  assign half_sel = offs_q[1] ? data_rdata_i[31:16] : data_rdata_i[15:0];
  assign msb      = (size_q == SIZE_HALF) ? half_sel[15] : byte_sel[7];

  always_comb
  begin
    case (ext_q)
      EXT_ZERO: fill = 1'b0;
      EXT_ONES: fill = 1'b1;
      default:  fill = msb;     // sign, both encodings
    endcase
  end

  always_comb
  begin
    case (size_q)
      SIZE_WORD: rdata_ext = data_rdata_i;                      // untouched
      SIZE_HALF: rdata_ext = {{(XLEN-16){fill}}, half_sel};
      default:   rdata_ext = {{(XLEN-8){fill}}, byte_sel};      // byte, both encodings
    endcase
  end

  ////////////////////
  // result hold
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !we_q)
      rdata_q <= rdata_ext;     // store acks leave it alone
  end

  // fresh data in the rvalid cycle, held copy otherwise
  assign rdata_ex_o = (data_rvalid_i && !we_q) ? rdata_ext : rdata_q;

endmodule

// ==== logic/lsu_pkg.sv ====
// fixed 32-bit datapath, halves must sit on even and words on word-aligned byte offsets
package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int XLEN   = 32; // data and address width
  localparam int BE_W   = 4;  // one enable per byte lane
  localparam int OFFS_W = 2;  // byte offset inside a word

  ////////////////////
  // encodings
  ////////////////////

  // transfer controller states
  typedef enum logic [1:0] {
    LSU_IDLE                 = 2'd0, // nothing outstanding
    LSU_WAIT_RVALID          = 2'd1, // granted, waiting for response
    LSU_WAIT_RVALID_EX_STALL = 2'd2, // granted while ex was stalled
    LSU_IDLE_EX_STALL        = 2'd3  // done, but ex still stalled
  } lsu_state_e;

  // access size as issued by the execute stage
  typedef enum logic [1:0] {
    SIZE_WORD     = 2'd0,
    SIZE_HALF     = 2'd1,
    SIZE_BYTE     = 2'd2,
    SIZE_BYTE_ALT = 2'd3  // decodes as byte
  } mem_size_e;

  // how the upper bits of a narrow load get filled
  typedef enum logic [1:0] {
    EXT_ZERO     = 2'd0,
    EXT_SIGN     = 2'd1,
    EXT_ONES     = 2'd2,
    EXT_SIGN_ALT = 2'd3  // decodes as sign
  } ext_mode_e;

  // byte lanes touched by an access of this size at this offset
  function automatic logic [BE_W-1:0] be_for_access(input mem_size_e size,
                                                    input logic [OFFS_W-1:0] offs);
    logic [BE_W-1:0] be;
    case (size)
      SIZE_WORD: be = 4'b1111;          // all lanes
      SIZE_HALF: be = 4'b0011 << offs;  // two lanes upward from offset
      default:   be = 4'b0001 << offs;  // single byte lane
    endcase
    return be;
  endfunction

endpackage

// ==== logic/lsu_store_path.sv ====
// purely combinational, byte enables and lane rotation are only right for aligned accesses
`timescale 1ns/100ps

module lsu_store_path
  import lsu_pkg::*;
(
  // address operands
  input  logic [XLEN-1:0]   operand_a_ex_i,
  input  logic [XLEN-1:0]   operand_b_ex_i,
  input  logic              addr_useincr_ex_i,  // a + b when set, else a

  // store attributes
  input  logic [XLEN-1:0]   wdata_ex_i,         // register value to store
  input  mem_size_e         size_ex_i,
  input  logic [OFFS_W-1:0] reg_offset_ex_i,    // where the data sits in the register

  // memory side
  output logic [XLEN-1:0]   data_addr_o,
  output logic [BE_W-1:0]   data_be_o,
  output logic [XLEN-1:0]   data_wdata_o,

  // to load path
  output logic [OFFS_W-1:0] addr_offs_o
);

  logic [XLEN-1:0]   addr;        // effective address
  logic [OFFS_W-1:0] wdata_offs;  // byte rotation amount
  logic [XLEN-1:0]   wdata_rot;

  ////////////////////
  // address
  ////////////////////
  assign addr        = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i)
                                         : operand_a_ex_i;
  assign addr_offs_o = addr[OFFS_W-1:0];   // low bits select the lane

  ////////////////////
  // byte enables
  ////////////////////
  assign data_be_o = be_for_access(size_ex_i, addr[OFFS_W-1:0]);

  ////////////////////
  // write data lanes
  ////////////////////

  // move the source bytes from register position to memory position,
  // wraps modulo 4 on purpose
  assign wdata_offs = addr[OFFS_W-1:0] - reg_offset_ex_i;

  always_comb
  begin
    case (wdata_offs)
      2'd0:    wdata_rot = wdata_ex_i;                               // already in place
      2'd1:    wdata_rot = {wdata_ex_i[23:0], wdata_ex_i[31:24]};    // up one byte
      2'd2:    wdata_rot = {wdata_ex_i[15:0], wdata_ex_i[31:16]};    // up two bytes
      default: wdata_rot = {wdata_ex_i[7:0],  wdata_ex_i[31:8]};     // up three bytes
    endcase
  end

  assign data_addr_o  = addr;
  assign data_wdata_o = wdata_rot;   // lanes outside data_be_o are don't care

endmodule

// ==== logic/lsu_top.sv ====
// 32-bit load/store unit, aligned accesses only, no bus errors or atomics, one transfer in flight
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // execute stage request
  input  logic              req_ex_i,
  input  logic              we_ex_i,
  input  mem_size_e         size_ex_i,
  input  ext_mode_e         sign_ext_ex_i,
  input  logic [XLEN-1:0]   wdata_ex_i,
  input  logic [OFFS_W-1:0] reg_offset_ex_i,
  input  logic [XLEN-1:0]   operand_a_ex_i,
  input  logic [XLEN-1:0]   operand_b_ex_i,
  input  logic              addr_useincr_ex_i,
  input  logic              ex_valid_i,

  // back to the pipeline
  output logic [XLEN-1:0]   rdata_ex_o,
  output logic              ready_ex_o,
  output logic              ready_wb_o,
  output logic              busy_o,

  // data memory port
  output logic              data_req_o,
  output logic [XLEN-1:0]   data_addr_o,
  output logic              data_we_o,
  output logic [BE_W-1:0]   data_be_o,
  output logic [XLEN-1:0]   data_wdata_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic [XLEN-1:0]   data_rdata_i
);

  logic [OFFS_W-1:0] addr_offs;  // low address bits for load alignment

  assign data_we_o = we_ex_i;    // direction straight from ex

  // request, ready and busy
  lsu_ctrl_fsm ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_ex_i      (req_ex_i),
    .ex_valid_i    (ex_valid_i),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .ready_ex_o    (ready_ex_o),
    .ready_wb_o    (ready_wb_o),
    .busy_o        (busy_o)
  );

  // address, enables, write lanes
  lsu_store_path store_i (
    .operand_a_ex_i    (operand_a_ex_i),
    .operand_b_ex_i    (operand_b_ex_i),
    .addr_useincr_ex_i (addr_useincr_ex_i),
    .wdata_ex_i        (wdata_ex_i),
    .size_ex_i         (size_ex_i),
    .reg_offset_ex_i   (reg_offset_ex_i),
    .data_addr_o       (data_addr_o),
    .data_be_o         (data_be_o),
    .data_wdata_o      (data_wdata_o),
    .addr_offs_o       (addr_offs)
  );

  // read data alignment and hold
  lsu_load_path load_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .we_ex_i       (we_ex_i),
    .size_ex_i     (size_ex_i),
    .sign_ext_ex_i (sign_ext_ex_i),
    .addr_offs_i   (addr_offs),
    .rdata_ex_o    (rdata_ex_o)
  );

endmodule

// ==== project.f ====
logic/lsu_pkg.sv
logic/lsu_ctrl_fsm.sv
logic/lsu_store_path.sv
logic/lsu_load_path.sv
logic/lsu_top.sv
bench/lsu_assertions.sv
bench/lsu_tb.sv
